/* include/qa_csr_map.svh */
`ifndef QA_CSR_MAP_SVH
`define QA_CSR_MAP_SVH

// Byte offsets in the AFU CSR window
localparam logic [13:0] CSR_AFU_DSM_BASEL         = 14'h1a00;
localparam logic [13:0] CSR_AFU_DSM_BASEH         = 14'h1a04;
localparam logic [13:0] CSR_AFU_CNTXT_BASEL       = 14'h1a08;
localparam logic [13:0] CSR_AFU_CNTXT_BASEH       = 14'h1a0c;
localparam logic [13:0] CSR_AFU_EN                = 14'h1a10;
localparam logic [13:0] CSR_AFU_READ_FRAME_BASEL  = 14'h1a14;
localparam logic [13:0] CSR_AFU_READ_FRAME_BASEH  = 14'h1a18;
localparam logic [13:0] CSR_AFU_WRITE_FRAME_BASEL = 14'h1a1c;
localparam logic [13:0] CSR_AFU_WRITE_FRAME_BASEH = 14'h1a20;

`endif

/* source/qa_cci_pkg.sv */
package qa_cci_pkg;

  localparam int CL_WIDTH    = 512;  // One cache line
  localparam int ADDR_WIDTH  = 32;   // Line address
  localparam int MDATA_WIDTH = 12;

  // Config write view of the receive header
  typedef struct packed {
    logic [5:0]  rsvd;
    logic [11:0] index;              // CSR dword index
  } cfg_hdr_t;

  // Response view of the receive header
  typedef struct packed {
    logic [1:0]             rsvd;
    logic [3:0]             resp_type;
    logic [MDATA_WIDTH-1:0] mdata;
  } resp_hdr_t;

  typedef union packed {
    cfg_hdr_t  cfg_hdr;
    resp_hdr_t resp_hdr;
  } rx_hdr_t;

  typedef struct packed {
    rx_hdr_t             header;
    logic [CL_WIDTH-1:0] data;
    logic                cfgvalid;
    logic                rdvalid;
  } rx_c0_t;

  typedef struct packed {
    rx_hdr_t header;
    logic    wrvalid;                // Write acknowledgement
  } rx_c1_t;

  typedef struct packed {
    logic                   valid;
    logic [ADDR_WIDTH-1:0]  addr;
    logic [MDATA_WIDTH-1:0] mdata;
  } tx_c0_t;

  typedef struct packed {
    logic                   valid;
    logic [ADDR_WIDTH-1:0]  addr;
    logic [MDATA_WIDTH-1:0] mdata;
    logic [CL_WIDTH-1:0]    data;
  } tx_c1_t;

endpackage

/* source/qa_csr_pkg.sv */
package qa_csr_pkg;

  `include "qa_csr_map.svh"

  typedef struct packed {
    logic [63:0] afu_dsm_base;
    logic        afu_dsm_base_valid;
    logic [63:0] afu_cntxt_base;
    logic        afu_cntxt_base_valid;
    logic [63:0] afu_read_frame;
    logic [63:0] afu_write_frame;
    logic        afu_en;
  } afu_csr_t;

  // Dword index from the config header to a byte offset
  function automatic logic [13:0] cfg_byte_offset(logic [11:0] index);
    return {index, 2'b00};
  endfunction

  // Replace one 32-bit half of a 64-bit base
  function automatic logic [63:0] set_half(logic [63:0] cur, logic hi, logic [31:0] val);
    logic [63:0] nxt;
    nxt = cur;
    if (hi) nxt[63:32] = val;
    else    nxt[31:0]  = val;
    return nxt;
  endfunction

endpackage

/* source/qa_csr.sv */
`timescale 1ns/1ps

module qa_csr (
  input  logic                 clk,
  input  logic                 resetb,
  input  qa_cci_pkg::rx_c0_t   rx0,
  output qa_csr_pkg::afu_csr_t csr
);
  import qa_csr_pkg::*;

  logic [13:0] cfg_offset;
  logic [31:0] cfg_data;

  logic [63:0] dsm_base;
  logic        dsm_valid;
  logic [63:0] cntxt_base;
  logic        cntxt_valid;
  logic [63:0] read_frame;
  logic [63:0] write_frame;
  logic        en;

  assign cfg_offset = cfg_byte_offset(rx0.header.cfg_hdr.index);
  assign cfg_data   = rx0.data[31:0];

  // Base address halves
  always_ff @(posedge clk) begin
    if (rx0.cfgvalid) begin
      case (cfg_offset)
        CSR_AFU_DSM_BASEL:         dsm_base    <= set_half(dsm_base, 1'b0, cfg_data);
        CSR_AFU_DSM_BASEH:         dsm_base    <= set_half(dsm_base, 1'b1, cfg_data);
        CSR_AFU_CNTXT_BASEL:       cntxt_base  <= set_half(cntxt_base, 1'b0, cfg_data);
        CSR_AFU_CNTXT_BASEH:       cntxt_base  <= set_half(cntxt_base, 1'b1, cfg_data);
        CSR_AFU_READ_FRAME_BASEL:  read_frame  <= set_half(read_frame, 1'b0, cfg_data);
        CSR_AFU_READ_FRAME_BASEH:  read_frame  <= set_half(read_frame, 1'b1, cfg_data);
        CSR_AFU_WRITE_FRAME_BASEL: write_frame <= set_half(write_frame, 1'b0, cfg_data);
        CSR_AFU_WRITE_FRAME_BASEH: write_frame <= set_half(write_frame, 1'b1, cfg_data);
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!resetb) begin
      dsm_valid   <= 1'b0;
      cntxt_valid <= 1'b0;
      en          <= 1'b0;
    end else if (rx0.cfgvalid) begin
      if (cfg_offset == CSR_AFU_DSM_BASEL) begin
        dsm_valid <= 1'b1;                         // Low half arms the base
      end
      if (cfg_offset == CSR_AFU_CNTXT_BASEL) begin
        cntxt_valid <= 1'b1;
      end
      if (cfg_offset == CSR_AFU_EN) begin
        en <= cfg_data[0];
      end
    end
  end

  always_comb begin
    csr.afu_dsm_base         = dsm_base;
    csr.afu_dsm_base_valid   = dsm_valid;
    csr.afu_cntxt_base       = cntxt_base;
    csr.afu_cntxt_base_valid = cntxt_valid;
    csr.afu_read_frame       = read_frame;
    csr.afu_write_frame      = write_frame;
    csr.afu_en               = en;
  end

endmodule

/* source/qa_rd_req.sv */
`timescale 1ns/1ps

module qa_rd_req #(
  parameter int NUM_LINES = 8
) (
  input  logic                 clk,
  input  logic                 resetb,
  input  qa_csr_pkg::afu_csr_t csr,
  input  logic                 tx0_almost_full,
  input  logic                 tx1_almost_full,
  output qa_cci_pkg::tx_c0_t   tx0
);

  localparam int IDX_W = (NUM_LINES > 1) ? $clog2(NUM_LINES) : 1;

  logic [IDX_W-1:0] line_idx;
  logic             started;
  logic             done;
  logic             issue;
  logic             last;

  logic             rd_valid;
  logic [31:0]      rd_addr;
  logic [11:0]      rd_mdata;

  assign last  = (line_idx == IDX_W'(NUM_LINES - 1));
  assign issue = csr.afu_en && csr.afu_dsm_base_valid && !done &&
                 !tx0_almost_full && !tx1_almost_full;

  always_ff @(posedge clk) begin
    if (!resetb) begin
      line_idx <= '0;
      started  <= 1'b0;
      done     <= 1'b0;
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= issue;
      if (issue) begin
        line_idx <= line_idx + 1'b1;
        started  <= 1'b1;
        if (last) begin
          done <= 1'b1;                            // All lines requested
        end
      end else if (started && !csr.afu_en) begin
        done <= 1'b1;                              // Disable ends the run for good
      end
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      rd_addr  <= csr.afu_read_frame[31:0] + 32'(line_idx);
      rd_mdata <= 12'(line_idx);                   // Tag is the line index
    end
  end

  always_comb begin
    tx0.valid = rd_valid;
    tx0.addr  = rd_addr;
    tx0.mdata = rd_mdata;
  end

endmodule

/* source/qa_wr_req.sv */
`timescale 1ns/1ps

module qa_wr_req #(
  parameter int NUM_LINES = 8
) (
  input  logic                 clk,
  input  logic                 resetb,
  input  qa_csr_pkg::afu_csr_t csr,
  input  qa_cci_pkg::rx_c0_t   rx0,
  input  qa_cci_pkg::rx_c1_t   rx1,
  output qa_cci_pkg::tx_c1_t   tx1
);
  import qa_cci_pkg::*;

  localparam int CNT_W = $clog2(NUM_LINES + 1);

  logic [CNT_W-1:0]    ack_cnt;
  logic                last_ack;
  logic                comp_pend;
  logic                comp_want;
  logic                comp_fire;
  logic [CL_WIDTH-1:0] comp_data;

  logic                wr_valid;
  logic [31:0]         wr_addr;
  logic [11:0]         wr_mdata;
  logic [CL_WIDTH-1:0] wr_data;

  assign last_ack  = rx1.wrvalid && (ack_cnt == CNT_W'(NUM_LINES - 1));
  assign comp_want = last_ack || comp_pend;
  assign comp_fire = comp_want && !rx0.rdvalid;   // Line copies win the slot

  always_comb begin
    comp_data        = '0;
    comp_data[0]     = 1'b1;
    comp_data[63:32] = 32'(NUM_LINES);            // Completed line count
  end

  always_ff @(posedge clk) begin
    if (!resetb) begin
      ack_cnt   <= '0;
      comp_pend <= 1'b0;
      wr_valid  <= 1'b0;
    end else begin
      if (rx1.wrvalid && ack_cnt != CNT_W'(NUM_LINES)) begin
        ack_cnt <= ack_cnt + 1'b1;               // Saturates, later acks ignored
      end
      comp_pend <= comp_want && rx0.rdvalid;
      wr_valid  <= rx0.rdvalid || comp_fire;
    end
  end

  always_ff @(posedge clk) begin
    if (rx0.rdvalid) begin
      wr_addr  <= csr.afu_write_frame[31:0] + 32'(rx0.header.resp_hdr.mdata);
      wr_mdata <= rx0.header.resp_hdr.mdata;
      wr_data  <= rx0.data;
    end else if (comp_fire) begin
      wr_addr  <= csr.afu_dsm_base[31:0];
      wr_mdata <= '1;                              // Completion tag
      wr_data  <= comp_data;
    end
  end

  always_comb begin
    tx1.valid = wr_valid;
    tx1.addr  = wr_addr;
    tx1.mdata = wr_mdata;
    tx1.data  = wr_data;
  end

endmodule

/* source/qa_top.sv */
`timescale 1ns/1ps

module qa_top #(
  parameter int NUM_LINES = 8
) (
  input  logic               clk,
  input  logic               resetb,
  input  qa_cci_pkg::rx_c0_t rx0,
  input  qa_cci_pkg::rx_c1_t rx1,
  input  logic               tx0_almost_full,
  input  logic               tx1_almost_full,
  output qa_cci_pkg::tx_c0_t tx0,
  output qa_cci_pkg::tx_c1_t tx1
);

  qa_csr_pkg::afu_csr_t csr;

  qa_csr u_csr (
    .clk    (clk),
    .resetb (resetb),
    .rx0    (rx0),
    .csr    (csr)
  );

  // Read side walks the source frame
  qa_rd_req #(
    .NUM_LINES (NUM_LINES)
  ) u_rd_req (
    .clk             (clk),
    .resetb          (resetb),
    .csr             (csr),
    .tx0_almost_full (tx0_almost_full),
    .tx1_almost_full (tx1_almost_full),
    .tx0             (tx0)
  );

  // Write side copies lines and posts completion
  qa_wr_req #(
    .NUM_LINES (NUM_LINES)
  ) u_wr_req (
    .clk    (clk),
    .resetb (resetb),
    .csr    (csr),
    .rx0    (rx0),
    .rx1    (rx1),
    .tx1    (tx1)
  );

endmodule

/* dv/qa_tb.sv */
`timescale 1ns/1ps

module qa_tb;
  import qa_cci_pkg::*;
  import qa_csr_pkg::*;

  localparam int NUM_LINES = 8;
  localparam int N_CFG     = 8;                  // Base records ahead of the enable
  localparam int SEED_AT   = 9;
  localparam int COUNT_AT  = 17;

  logic                clk;
  logic                resetb;
  rx_c0_t              rx0;
  rx_c1_t              rx1;
  logic                tx0_almost_full;
  logic                tx1_almost_full;
  tx_c0_t              tx0;
  tx_c1_t              tx1;

  logic [63:0]         td [0:COUNT_AT];
  logic [CL_WIDTH-1:0] src_line [NUM_LINES];
  logic [11:0]         rd_tag [NUM_LINES];
  int                  rd_due [NUM_LINES];
  int                  rd_seen [NUM_LINES];
  int                  wr_seen [NUM_LINES];
  int                  test_err [1:5];
  logic [31:0]         dsm_lo;
  logic [31:0]         rd_lo;
  logic [31:0]         wr_lo;
  logic [31:0]         exp_count;
  logic [31:0]         rng;
  logic [47:0]         cfg_q [$];
  int                  ack_q [$];
  int                  cycle;
  int                  rd_count;
  int                  ack_count;
  int                  comp_count;
  int                  bp_cnt;
  logic                bp_done;
  logic                idle_check;

  qa_top #(.NUM_LINES(NUM_LINES)) uut (
    .clk             (clk),
    .resetb          (resetb),
    .rx0             (rx0),
    .rx1             (rx1),
    .tx0_almost_full (tx0_almost_full),
    .tx1_almost_full (tx1_almost_full),
    .tx0             (tx0),
    .tx1             (tx1)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] xorshift(logic [31:0] s);
    s ^= s << 13;
    s ^= s >> 17;
    s ^= s << 5;
    return s;
  endfunction

  function automatic int rand_delay();
    rng = xorshift(rng);
    return 1 + int'(rng % 8);                    // 1 to 8 cycles
  endfunction

  function automatic logic [CL_WIDTH-1:0] expand_line(logic [63:0] seed);
    logic [CL_WIDTH-1:0] line;
    for (int k = 0; k < CL_WIDTH / 64; k++) begin
      line[k*64 +: 64] = seed ^ (64'h0101_0101_0101_0101 * k);
    end
    return line;
  endfunction

  task automatic flag_error(int t, string msg);
    $display("%s", msg);
    test_err[t]++;
  endtask

  task automatic check_copy();
    logic [11:0] tag;
    tag = tx1.mdata;
    if (tag >= NUM_LINES) begin
      flag_error(4, $sformatf("FAIL tx1.mdata got %h expected below %h", tag, NUM_LINES));
    end else begin
      wr_seen[tag]++;
      if (tx1.addr !== wr_lo + 32'(tag))
        flag_error(4, $sformatf("FAIL tx1.addr got %h expected %h", tx1.addr, wr_lo + 32'(tag)));
      if (tx1.data !== src_line[tag])
        flag_error(4, $sformatf("FAIL tx1.data got %h expected %h", tx1.data, src_line[tag]));
    end
  endtask

  task automatic check_completion();
    comp_count++;
    if (ack_count != NUM_LINES)
      flag_error(5, $sformatf("Completion written after only %0d acknowledgements", ack_count));
    if (tx1.data[0] !== 1'b1)
      flag_error(5, $sformatf("FAIL tx1.data[0] got %h expected 1", tx1.data[0]));
    if (tx1.data[63:32] !== exp_count)
      flag_error(5, $sformatf("FAIL tx1.data[63:32] got %h expected %h",
                              tx1.data[63:32], exp_count));
    if (tx1.mdata !== 12'hfff)
      flag_error(5, $sformatf("FAIL tx1.mdata got %h expected fff", tx1.mdata));
  endtask

  task automatic report_test(int t, string name);
    if (test_err[t] == 0) $display("Test %0d %s: ok", t, name);
    else $display("Test %0d %s: %0d errors", t, name, test_err[t]);
  endtask

  // Host model samples the registered outputs then drives the next cycle
  always @(negedge clk) begin : host
    int          pick;
    logic [31:0] idx;
    logic [47:0] rec;
    cycle++;
    if (idle_check && resetb && (tx0.valid !== 1'b0 || tx1.valid !== 1'b0))
      flag_error(1, $sformatf("FAIL tx0.valid got %h tx1.valid got %h expected 0 while idle",
                              tx0.valid, tx1.valid));
    if ((tx0_almost_full || tx1_almost_full) && tx0.valid !== 1'b0)
      flag_error(3, $sformatf("FAIL tx0.valid got %h expected 0 under almost-full", tx0.valid));
    if (tx0.valid === 1'b1) begin
      rd_count++;
      idx = tx0.addr - rd_lo;                    // Line picked by address
      if (tx0.addr !== rd_lo + 32'(tx0.mdata))
        flag_error(2, $sformatf("FAIL tx0.addr got %h expected %h", tx0.addr,
                                rd_lo + 32'(tx0.mdata)));
      if (idx >= NUM_LINES) begin
        flag_error(2, "Read request addressed outside the read frame");
      end else begin
        rd_seen[idx]++;
        rd_due[idx] = cycle + rand_delay();
        rd_tag[idx] = tx0.mdata;
      end
    end
    if (tx1.valid === 1'b1) begin
      ack_q.push_back(cycle + rand_delay());
      if (tx1.addr === dsm_lo) check_completion();
      else check_copy();
    end
    rx0 = '0;
    rx1 = '0;
    if (cfg_q.size() > 0) begin
      rec = cfg_q.pop_front();
      rx0.header.cfg_hdr.index = rec[45:34];
      rx0.data[31:0]           = rec[31:0];
      rx0.cfgvalid             = 1'b1;
    end else begin
      pick = -1;
      for (int i = NUM_LINES - 1; i >= 0; i--) begin
        if (rd_due[i] >= 0 && rd_due[i] <= cycle) pick = i;
      end
      if (pick >= 0) begin
        rx0.header.resp_hdr.mdata = rd_tag[pick];
        rx0.data                  = src_line[pick];
        rx0.rdvalid               = 1'b1;
        rd_due[pick]              = -1;
      end
    end
    for (int i = 0; i < ack_q.size(); i++) begin
      if (ack_q[i] <= cycle && !rx1.wrvalid) begin
        ack_q.delete(i);
        rx1.wrvalid = 1'b1;
        ack_count++;
      end
    end
    if (!bp_done && rd_count >= 3) begin
      tx0_almost_full = (bp_cnt < 6);            // Overlapping windows on both levels
      tx1_almost_full = (bp_cnt >= 4) && (bp_cnt < 10);
      bp_cnt++;
      bp_done = (bp_cnt > 10);
    end
  end

  initial begin
    repeat (2000 + 50 * NUM_LINES) @(posedge clk);
    $display("Timeout: the completion write never arrived");
    $display("FAIL: see errors above");
    $finish;
  end

  initial begin
    int failed;
    int total;
    rng = 32'h7d9a_e926;
    resetb = 1'b0;
    rx0 = '0;
    rx1 = '0;
    tx0_almost_full = 1'b0;
    tx1_almost_full = 1'b0;
    cycle = 0;
    rd_count = 0;
    ack_count = 0;
    comp_count = 0;
    bp_cnt = 0;
    bp_done = 1'b0;
    idle_check = 1'b1;
    for (int i = 0; i < NUM_LINES; i++) begin
      rd_due[i] = -1;
      rd_seen[i] = 0;
      wr_seen[i] = 0;
    end
    for (int t = 1; t <= 5; t++) test_err[t] = 0;
    $readmemh("dv/qa_testdata.txt", td);
    for (int i = 0; i < N_CFG; i++) begin
      case (td[i][45:32])
        CSR_AFU_DSM_BASEL:         dsm_lo = td[i][31:0];
        CSR_AFU_READ_FRAME_BASEL:  rd_lo  = td[i][31:0];
        CSR_AFU_WRITE_FRAME_BASEL: wr_lo  = td[i][31:0];
        default: ;
      endcase
    end
    exp_count = td[COUNT_AT][31:0];
    for (int i = 0; i < NUM_LINES; i++) src_line[i] = expand_line(td[SEED_AT + i]);
    repeat (8) @(negedge clk);
    resetb = 1'b1;
    @(posedge clk);
    for (int i = 0; i < N_CFG; i++) cfg_q.push_back(td[i][47:0]);
    while (cfg_q.size() != 0) @(posedge clk);
    repeat (10) @(posedge clk);                  // Bases set while still disabled
    idle_check = 1'b0;
    report_test(1, "reset and idle");
    cfg_q.push_back(td[N_CFG][47:0]);
    wait (comp_count > 0);
    repeat (30) @(posedge clk);
    for (int i = 0; i < NUM_LINES; i++) begin
      if (rd_seen[i] != 1) flag_error(2, $sformatf("Line %0d read %0d times", i, rd_seen[i]));
      if (wr_seen[i] != 1) flag_error(4, $sformatf("Line %0d written %0d times", i, wr_seen[i]));
    end
    if (!bp_done || rd_count != NUM_LINES)
      flag_error(3, "Reads did not resume fully after the almost-full window");
    if (comp_count != 1)
      flag_error(5, $sformatf("Completion written %0d times instead of once", comp_count));
    report_test(2, "read addressing");
    report_test(3, "back-pressure");
    report_test(4, "copy correctness");
    report_test(5, "completion");
    failed = 0;
    total = 0;
    for (int t = 1; t <= 5; t++) begin
      if (test_err[t] != 0) failed++;
      total += test_err[t];
    end
    $display("Tests run 5, failed %0d, errors %0d", failed, total);
    if (total == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

/* dv/qa_testdata.txt */
// Records 0-8: CSR write, bits 45:32 byte offset, bits 31:0 value (record 8 is the enable)
// Records 9-16: source line seeds, word k of a line is seed ^ (k * 64'h0101_0101_0101_0101)
// Record 17: expected completed line count
0000_1a00_0000_4000
0000_1a04_0000_0001
0000_1a08_0000_6000
0000_1a0c_0000_0001
0000_1a14_0002_0000
0000_1a18_0000_0001
0000_1a1c_0003_0000
0000_1a20_0000_0001
0000_1a10_0000_0001
0123_4567_89ab_cdef
fedc_ba98_7654_3210
a5a5_5a5a_0f0f_f0f0
dead_beef_cafe_f00d
1357_9bdf_2468_ace0
8000_0000_0000_0001
3c3c_c3c3_6969_9696
0f1e_2d3c_4b5a_6978
0000_0000_0000_0008

/* compile.f */
+incdir+include
source/qa_cci_pkg.sv
source/qa_csr_pkg.sv
source/qa_csr.sv
source/qa_rd_req.sv
source/qa_wr_req.sv
source/qa_top.sv
dv/qa_tb.sv
